//--- include/zx_config.svh
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// raster size in pixels and lines
`define ZX_H_TOTAL 64
`define ZX_H_SYNC 8
`define ZX_V_TOTAL 32
`define ZX_V_SYNC 2

// reset stretch counter width
`define ZX_RST_CNT_SIZE 6

// spi register numbers
`define ZX_SPI_REG_CFG0 8'h80
`define ZX_SPI_REG_RST 8'h90

// port #FE is decoded on this address bit being low
`define ZX_FE_ABIT 0

`endif

//--- src/zbus_pkg.sv
package zbus_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;

	// bit 0 blue, bit 1 red, bit 2 green
	typedef logic [2:0] border_t;

	// data byte written to port #FE
	typedef struct packed {
		logic [2:0] unused;
		logic beeper;
		logic tape_out;
		border_t border;
	} port_fe_t;

	typedef struct packed {
		logic [3:0] unused;
		logic beeper_mux;
		logic tape_read;
		logic set_nmi;
		logic vga_on;
	} config0_t;

	// register number on the first spi byte, config fields on the second
	typedef union packed {
		logic [7:0] raw;
		config0_t cfg;
	} cfg_word_u;

endpackage

//--- src/video_pkg.sv
`include "zx_config.svh"

package video_pkg;

	// one colour channel, two bits per gun
	typedef logic [1:0] chan_t;

	localparam chan_t CHAN_OFF = 2'b00;
	localparam chan_t CHAN_ON = 2'b10;

	// pixel within a line
	typedef logic [$clog2(`ZX_H_TOTAL)-1:0] hcnt_t;

	// line within a frame
	typedef logic [$clog2(`ZX_V_TOTAL)-1:0] vcnt_t;

endpackage

//--- src/zx_ifs.sv
// phase strobes from fclk
interface phase_if;
	logic f0;
	logic f1;
	logic h0;
	logic h1;
	logic c0;
	logic c1;
	logic c2;
	logic c3;

	modport src(output f0, f1, h0, h1, c0, c1, c2, c3);
	modport snk(input f0, f1, h0, h1, c0, c1, c2, c3);
endinterface

// synchronised z80 bus
interface zbus_if;
	import zbus_pkg::*;

	logic iorq;
	logic mreq;
	logic rd;
	logic wr;
	logic iowr_s;
	zaddr_t a;
	zdata_t d;

	modport src(output iorq, mreq, rd, wr, iowr_s, a, d);
	modport snk(input iorq, mreq, rd, wr, iowr_s, a, d);
endinterface

//--- src/clock.sv
module clock (
	input logic fclk,
	input logic rst,
	phase_if.src ph
);

	logic [1:0] phase;

	always_ff @(posedge fclk) begin
		if (rst)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	// f pair toggles every fclk, c strobes rotate over four
	assign ph.f0 = ~phase[0];
	assign ph.f1 = phase[0];
	assign ph.c0 = (phase == 2'd0);
	assign ph.c1 = (phase == 2'd1);
	assign ph.c2 = (phase == 2'd2);
	assign ph.c3 = (phase == 2'd3);
	assign ph.h0 = ph.c0;
	assign ph.h1 = ph.c2;

	a_c_onehot: assert property (@(posedge fclk) disable iff (rst)
		$onehot({ph.c3, ph.c2, ph.c1, ph.c0}));

endmodule

//--- src/zsignals.sv
module zsignals (
	input logic fclk,
	input logic rst,
	input logic iorq_n,
	input logic mreq_n,
	input logic rd_n,
	input logic wr_n,
	input logic m1_n,
	input logic rfsh_n,
	input logic [15:0] a,
	input logic [7:0] d,
	zbus_if.src bus
);
	import zbus_pkg::*;

	// {iorq_n, mreq_n, rd_n, wr_n, m1_n, rfsh_n}
	logic [5:0] ctl_s1;
	logic [5:0] ctl_s2;
	zaddr_t a_s1;
	zaddr_t a_s2;
	zdata_t d_s1;
	zdata_t d_s2;
	logic m1;
	logic rfsh;
	logic iowr;
	logic iowr_r;
	logic iowr_s;

	always_ff @(posedge fclk) begin
		if (rst) begin
			ctl_s1 <= '1;
			ctl_s2 <= '1;
		end else begin
			ctl_s1 <= {iorq_n, mreq_n, rd_n, wr_n, m1_n, rfsh_n};
			ctl_s2 <= ctl_s1;
		end
	end

	always_ff @(posedge fclk) begin
		a_s1 <= a;
		a_s2 <= a_s1;
		d_s1 <= d;
		d_s2 <= d_s1;
	end

	assign m1 = ~ctl_s2[1];
	assign rfsh = ~ctl_s2[0];

	assign bus.iorq = ~ctl_s2[5];
	// refresh cycles are not memory accesses
	assign bus.mreq = ~ctl_s2[4] & ~rfsh;
	assign bus.rd = ~ctl_s2[3];
	assign bus.wr = ~ctl_s2[2];
	assign bus.a = a_s2;
	assign bus.d = d_s2;

	// iorq with m1 is an interrupt acknowledge
	assign iowr = bus.iorq & bus.wr & ~m1;

	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_r <= 1'b0;
			iowr_s <= 1'b0;
		end else begin
			iowr_r <= iowr;
			iowr_s <= iowr & ~iowr_r;
		end
	end

	assign bus.iowr_s = iowr_s;

	a_iowr_pulse: assert property (@(posedge fclk) disable iff (rst)
		iowr_s |=> !iowr_s);

endmodule

//--- src/resetter.sv
`include "zx_config.svh"

module resetter (
	input logic fclk,
	input logic reset,
	input logic genrst,
	output logic rst
);

	logic [`ZX_RST_CNT_SIZE-1:0] cnt;
	logic req;

	assign req = reset | genrst;

	// reload on request, release once the count is full
	always_ff @(posedge fclk) begin
		if (req) begin
			cnt <= '0;
			rst <= 1'b1;
		end else if (rst) begin
			cnt <= cnt + 1'b1;
			if (&cnt)
				rst <= 1'b0;
		end
	end

endmodule

//--- src/slavespi.sv
`include "zx_config.svh"

module slavespi (
	input logic fclk,
	input logic rst,
	input logic spics_n,
	input logic spick,
	input logic spido,
	output logic spidi,
	output zbus_pkg::config0_t config0,
	output logic genrst
);
	import zbus_pkg::*;

	// {spics_n, spick, spido}
	logic [2:0] sync1;
	logic [2:0] sync2;
	logic sck_prev;
	logic sck_rise;
	logic byte_done;
	logic [2:0] bit_cnt;
	logic data_byte;
	cfg_word_u sh;
	cfg_word_u sh_next;
	logic [7:0] reg_num;
	logic [7:0] rd_sh;

	always_ff @(posedge fclk) begin
		if (rst) begin
			sync1 <= 3'b100;
			sync2 <= 3'b100;
			sck_prev <= 1'b0;
		end else begin
			sync1 <= {spics_n, spick, spido};
			sync2 <= sync1;
			sck_prev <= sync2[1];
		end
	end

	assign sck_rise = sync2[1] & ~sck_prev & ~sync2[2];
	assign byte_done = sck_rise & (bit_cnt == 3'd7);
	assign sh_next.raw = {sh.raw[6:0], sync2[0]};

	always_ff @(posedge fclk) begin
		if (sck_rise)
			sh <= sh_next;
	end

	// first byte of a select period names the register
	always_ff @(posedge fclk) begin
		if (byte_done && !data_byte)
			reg_num <= sh_next.raw;
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			bit_cnt <= '0;
			data_byte <= 1'b0;
			config0 <= '0;
			genrst <= 1'b0;
			rd_sh <= '0;
		end else begin
			genrst <= 1'b0;
			if (sync2[2]) begin
				// deselect drops any partial byte
				bit_cnt <= '0;
				data_byte <= 1'b0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				rd_sh <= {rd_sh[6:0], 1'b0};
				if (byte_done) begin
					data_byte <= 1'b1;
					if (!data_byte)
						rd_sh <= config0;
					else if (reg_num == `ZX_SPI_REG_CFG0)
						config0 <= sh_next.cfg;
					else if (reg_num == `ZX_SPI_REG_RST)
						genrst <= 1'b1;
				end
			end
		end
	end

	// readback, msb first
	assign spidi = rd_sh[7];

	a_rst_no_cfg: assert property (@(posedge fclk) disable iff (rst)
		genrst |-> $stable(config0));

endmodule

//--- src/port_fe.sv
`include "zx_config.svh"

module port_fe (
	input logic fclk,
	input logic rst,
	zbus_if.snk bus,
	input zbus_pkg::config0_t config0,
	output zbus_pkg::border_t border,
	output logic beep
);
	import zbus_pkg::*;

	port_fe_t wdata;
	logic fe_wr;
	logic tape_out;
	logic beeper;

	assign wdata = bus.d;
	assign fe_wr = bus.iowr_s & ~bus.a[`ZX_FE_ABIT];

	always_ff @(posedge fclk) begin
		if (rst) begin
			border <= '0;
			tape_out <= 1'b0;
			beeper <= 1'b0;
		end else if (fe_wr) begin
			border <= wdata.border;
			tape_out <= wdata.tape_out;
			beeper <= wdata.beeper;
		end
	end

	assign beep = config0.beeper_mux ? tape_out : beeper;

	// write strobe only ever comes from a clean io write cycle
	a_iowr_clean: assert property (@(posedge fclk) disable iff (rst)
		bus.iowr_s |-> bus.iorq && bus.wr && !bus.rd && !bus.mreq);

endmodule

//--- src/video_top.sv
`include "zx_config.svh"

module video_top (
	input logic fclk,
	input logic rst,
	phase_if.snk ph,
	input zbus_pkg::config0_t config0,
	input zbus_pkg::border_t border,
	output video_pkg::chan_t vred,
	output video_pkg::chan_t vgrn,
	output video_pkg::chan_t vblu,
	output logic hsync,
	output logic vsync,
	output logic csync
);
	import zbus_pkg::*;
	import video_pkg::*;

	logic pix_en;
	hcnt_t hcnt;
	vcnt_t vcnt;
	border_t border_q;
	logic hs_d;
	logic vs_d;
	logic blank;

	function automatic chan_t level(input logic on);
		return on ? CHAN_ON : CHAN_OFF;
	endfunction

	// vga doubles the pixel rate
	assign pix_en = config0.vga_on ? ph.f1 : ph.c3;

	always_ff @(posedge fclk) begin
		if (rst) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (pix_en) begin
			if (hcnt == hcnt_t'(`ZX_H_TOTAL - 1)) begin
				hcnt <= '0;
				if (vcnt == vcnt_t'(`ZX_V_TOTAL - 1))
					vcnt <= '0;
				else
					vcnt <= vcnt + vcnt_t'(1);
			end else begin
				hcnt <= hcnt + hcnt_t'(1);
			end
		end
	end

	always_ff @(posedge fclk) begin
		if (pix_en)
			border_q <= border;
	end

	assign hs_d = (hcnt < hcnt_t'(`ZX_H_SYNC));
	assign vs_d = (vcnt < vcnt_t'(`ZX_V_SYNC));
	assign blank = hs_d | vs_d;

	always_ff @(posedge fclk) begin
		if (rst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b0;
			vred <= CHAN_OFF;
			vgrn <= CHAN_OFF;
			vblu <= CHAN_OFF;
		end else begin
			hsync <= hs_d;
			vsync <= vs_d;
			csync <= blank;
			vred <= blank ? CHAN_OFF : level(border_q[1]);
			vgrn <= blank ? CHAN_OFF : level(border_q[2]);
			vblu <= blank ? CHAN_OFF : level(border_q[0]);
		end
	end

	a_csync: assert property (@(posedge fclk) disable iff (rst)
		csync == (hsync | vsync));

endmodule

//--- src/zx_top.sv
module zx_top (
	input logic fclk,
	input logic reset,
	input logic iorq_n,
	input logic mreq_n,
	input logic rd_n,
	input logic wr_n,
	input logic m1_n,
	input logic rfsh_n,
	input logic [15:0] a,
	input logic [7:0] d,
	output logic res,
	output logic beep,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic vhsync,
	output logic vvsync,
	output logic vcsync,
	input logic spics_n,
	input logic spick,
	input logic spido,
	output logic spidi
);
	import zbus_pkg::*;

	logic rst;
	logic genrst;
	config0_t config0;
	border_t border;

	phase_if ph();
	zbus_if zbus();

	clock clock (
		.fclk(fclk),
		.rst(rst),
		.ph(ph)
	);

	zsignals zsignals (
		.fclk(fclk),
		.rst(rst),
		.iorq_n(iorq_n),
		.mreq_n(mreq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.m1_n(m1_n),
		.rfsh_n(rfsh_n),
		.a(a),
		.d(d),
		.bus(zbus)
	);

	// global reset, also raised from spi
	resetter resetter (
		.fclk(fclk),
		.reset(reset),
		.genrst(genrst),
		.rst(rst)
	);

	slavespi slavespi (
		.fclk(fclk),
		.rst(rst),
		.spics_n(spics_n),
		.spick(spick),
		.spido(spido),
		.spidi(spidi),
		.config0(config0),
		.genrst(genrst)
	);

	port_fe port_fe (
		.fclk(fclk),
		.rst(rst),
		.bus(zbus),
		.config0(config0),
		.border(border),
		.beep(beep)
	);

	video_top video_top (
		.fclk(fclk),
		.rst(rst),
		.ph(ph),
		.config0(config0),
		.border(border),
		.vred(vred),
		.vgrn(vgrn),
		.vblu(vblu),
		.hsync(vhsync),
		.vsync(vvsync),
		.csync(vcsync)
	);

	assign res = rst;

endmodule

//--- testbench/tb_zx_top.sv
`include "zx_config.svh"

module tb_zx_top;
	import zbus_pkg::*;
	import video_pkg::*;

	localparam integer LINE_TV = `ZX_H_TOTAL * 4;
	localparam integer LINE_VGA = `ZX_H_TOTAL * 2;
	localparam integer FRAME_VGA = LINE_VGA * `ZX_V_TOTAL;
	localparam integer MID_WAIT = (`ZX_H_TOTAL - `ZX_H_SYNC) / 2 * 2;
	localparam integer RST_LEN = (1 << `ZX_RST_CNT_SIZE) + 8;
	localparam integer N_WR = 40;
	localparam integer N_BEEP = 8;
	localparam integer N_CFG = 8;
	localparam integer SPI_LEN = 16 * 8 + 20;
	// each line wait may have to skip the vsync lines
	localparam integer MAX_CYCLES = 2 * RST_LEN + 4 * LINE_TV + 4 * FRAME_VGA
		+ (N_WR + 1) * (20 + (`ZX_V_SYNC + 2) * LINE_VGA)
		+ N_BEEP * 20 + (N_CFG + 8) * SPI_LEN;

	logic fclk;
	logic reset;
	logic iorq_n;
	logic mreq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	logic rfsh_n;
	logic [15:0] a;
	logic [7:0] d;
	logic res;
	logic beep;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;
	logic vhsync;
	logic vvsync;
	logic vcsync;
	logic spics_n;
	logic spick;
	logic spido;
	logic spidi;

	integer seed;
	integer cycles;
	integer res_rise_at = 0;
	integer res_fall_at = 0;
	logic res_prev;
	integer border_errs = 0;
	integer beep_errs = 0;
	integer period_errs = 0;
	integer config_errs = 0;
	integer sync_errs = 0;
	port_fe_t model_fe;
	config0_t model_cfg;

	zx_top DUT (.*);

	initial begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge fclk);
			cycles = cycles + 1;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	// edge stamps of res, in fclk edges
	always @(negedge fclk) begin
		if (res === 1'b1 && res_prev !== 1'b1)
			res_rise_at = cycles;
		if (res === 1'b0 && res_prev === 1'b1)
			res_fall_at = cycles;
		res_prev = res;
	end

	function automatic chan_t chan_of(input logic on);
		return on ? 2'b10 : 2'b00;
	endfunction

	task automatic check_border(input string name, input chan_t er, input chan_t eg,
			input chan_t eb, input chan_t ar, input chan_t ag, input chan_t ab);
		if ({ar, ag, ab} !== {er, eg, eb}) begin
			border_errs = border_errs + 1;
			$display("MISMATCH %s: expected rgb %b %b %b, actual %b %b %b",
				name, er, eg, eb, ar, ag, ab);
		end
	endtask

	task automatic check_beep(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			beep_errs = beep_errs + 1;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_sync(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			sync_errs = sync_errs + 1;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_period(input string name, input integer exp, input integer act);
		if (act !== exp) begin
			period_errs = period_errs + 1;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_config(input string name, input config0_t exp, input config0_t act);
		if (act !== exp) begin
			config_errs = config_errs + 1;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_line_colours(input string name);
		check_border(name, chan_of(model_fe.border[1]), chan_of(model_fe.border[2]),
			chan_of(model_fe.border[0]), vred, vgrn, vblu);
	endtask

	task automatic wait_rise(input logic use_v);
		logic prev;
		logic cur;
		@(negedge fclk);
		prev = use_v ? vvsync : vhsync;
		cur = prev;
		while (!(cur && !prev)) begin
			prev = cur;
			@(negedge fclk);
			cur = use_v ? vvsync : vhsync;
		end
	endtask

	task automatic measure_period(input logic use_v, output integer n);
		integer start;
		wait_rise(use_v);
		start = cycles;
		wait_rise(use_v);
		n = cycles - start;
	endtask

	// middle of the visible part of the next non-vsync line, vga rate
	task automatic wait_visible_mid;
		do
			wait_rise(1'b0);
		while (vvsync);
		while (vhsync)
			@(negedge fclk);
		repeat (MID_WAIT) @(negedge fclk);
	endtask

	// kind 0/1 io write, 2 memory write, 3 io write with m1 low
	task automatic bus_write(input logic [1:0] kind, input zaddr_t addr, input zdata_t data);
		@(posedge fclk);
		a <= addr;
		d <= data;
		wr_n <= 1'b0;
		if (kind == 2'd2)
			mreq_n <= 1'b0;
		else
			iorq_n <= 1'b0;
		if (kind == 2'd3)
			m1_n <= 1'b0;
		repeat (6) @(posedge fclk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		wr_n <= 1'b1;
		m1_n <= 1'b1;
		repeat (4) @(posedge fclk);
	endtask

	// spi mode 0, four fclk per half period
	task automatic spi_bit(input logic b, output logic q);
		@(posedge fclk);
		spick <= 1'b0;
		spido <= b;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		q = spidi;
		@(posedge fclk);
		spick <= 1'b1;
		repeat (3) @(posedge fclk);
	endtask

	task automatic spi_xfer(input zdata_t regnum, input zdata_t data, input integer nbits,
			output zdata_t rd);
		logic [15:0] word;
		logic q;
		integer i;
		word = {regnum, data};
		rd = '0;
		@(posedge fclk);
		spics_n <= 1'b0;
		repeat (4) @(posedge fclk);
		for (i = 0; i < nbits; i = i + 1) begin
			spi_bit(word[15], q);
			word = word << 1;
			if (i >= 8)
				rd = {rd[6:0], q};
		end
		@(posedge fclk);
		spick <= 1'b0;
		repeat (4) @(posedge fclk);
		spics_n <= 1'b1;
		repeat (6) @(posedge fclk);
	endtask

	task automatic write_config(input string name, input zdata_t value);
		zdata_t rd;
		spi_xfer(`ZX_SPI_REG_CFG0, value, 16, rd);
		check_config(name, model_cfg, rd);
		model_cfg = value;
	endtask

	initial begin
		integer i;
		integer rnd;
		integer hper;
		integer vper;
		logic [1:0] kind;
		zaddr_t addr;
		zdata_t rd;
		seed = 59555;
		model_fe = '0;
		model_cfg = '0;
		reset <= 1'b1;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		m1_n <= 1'b1;
		rfsh_n <= 1'b1;
		a <= '0;
		d <= '0;
		spics_n <= 1'b1;
		spick <= 1'b0;
		spido <= 1'b0;
		repeat (8) @(posedge fclk);
		reset <= 1'b0;

		while (res !== 1'b0)
			@(negedge fclk);
		@(negedge fclk);
		check_period("power-on reset", RST_LEN, res_fall_at);

		measure_period(1'b0, hper);
		check_period("hsync tv", LINE_TV, hper);
		write_config("vga on", 8'h01);
		measure_period(1'b0, hper);
		check_period("hsync vga", LINE_VGA, hper);
		measure_period(1'b1, vper);
		check_period("vsync vga", `ZX_V_TOTAL * hper, vper);

		// only even io ports reach the border
		for (i = 0; i < N_WR; i = i + 1) begin
			rnd = $random(seed);
			kind = rnd[25:24];
			bus_write(kind, rnd[15:0], rnd[23:16]);
			if (kind[1] == 1'b0 && rnd[`ZX_FE_ABIT] == 1'b0)
				model_fe = rnd[23:16];
			wait_visible_mid();
			check_line_colours($sformatf("write %0d", i));
			check_sync($sformatf("csync visible %0d", i), 1'b0, vcsync);
			check_beep($sformatf("beeper %0d", i), model_fe.beeper, beep);
		end

		// lit border with tape bit set, then look inside both syncs
		bus_write(2'd0, 16'h00fe, 8'h0f);
		model_fe = 8'h0f;
		wait_rise(1'b0);
		wait_rise(1'b0);
		check_border("hsync blank", 2'b00, 2'b00, 2'b00, vred, vgrn, vblu);
		check_sync("csync in hsync", 1'b1, vcsync);
		wait_rise(1'b1);
		while (vhsync)
			@(negedge fclk);
		repeat (MID_WAIT) @(negedge fclk);
		check_border("vsync blank", 2'b00, 2'b00, 2'b00, vred, vgrn, vblu);
		check_sync("csync in vsync", 1'b1, vcsync);

		write_config("beeper mux", 8'h09);
		@(negedge fclk);
		check_beep("tape mux", model_fe.tape_out, beep);
		for (i = 0; i < N_BEEP; i = i + 1) begin
			rnd = $random(seed);
			addr = rnd[15:0];
			addr[`ZX_FE_ABIT] = 1'b0;
			bus_write(2'd0, addr, rnd[23:16]);
			model_fe = rnd[23:16];
			@(negedge fclk);
			check_beep($sformatf("tape out %0d", i), model_fe.tape_out, beep);
		end

		for (i = 0; i < N_CFG; i = i + 1) begin
			rnd = $random(seed);
			write_config($sformatf("config %0d", i), rnd[7:0]);
		end
		// cut in the data byte, then in the register byte
		rnd = $random(seed);
		spi_xfer(`ZX_SPI_REG_CFG0, rnd[7:0], 12, rd);
		spi_xfer(`ZX_SPI_REG_CFG0, rnd[15:8], 5, rd);
		spi_xfer(8'h00, 8'h00, 16, rd);
		check_config("cut transfer", model_cfg, rd);

		spi_xfer(`ZX_SPI_REG_RST, 8'h00, 16, rd);
		while (res !== 1'b0)
			@(negedge fclk);
		@(negedge fclk);
		check_period("spi reset", 1 << `ZX_RST_CNT_SIZE, res_fall_at - res_rise_at);
		model_cfg = '0;
		model_fe = '0;
		spi_xfer(8'h00, 8'h00, 16, rd);
		check_config("config after spi reset", model_cfg, rd);

		$display("errors: border %0d, beep %0d, period %0d, config %0d, sync %0d",
			border_errs, beep_errs, period_errs, config_errs, sync_errs);
		if (border_errs + beep_errs + period_errs + config_errs + sync_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
src/zbus_pkg.sv
src/video_pkg.sv
src/zx_ifs.sv
src/clock.sv
src/zsignals.sv
src/resetter.sv
src/slavespi.sv
src/port_fe.sv
src/video_top.sv
src/zx_top.sv
testbench/tb_zx_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP := tb_zx_top
FILELIST := sim.f
OBJ_DIR := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
